/* build.f */
+incdir+include
hdl/rom_map_pkg.sv
hdl/rom_bus_pkg.sv
hdl/rom_port_if.sv
hdl/rom_loader.sv
hdl/rom_bank_store.sv
hdl/rom_fetch_mux.sv
hdl/sys1_rom_top.sv
bench/tb_sys1_rom.sv

/* bench/tb_sys1_rom.sv */
// Fixed seed random stimulus; reads start 3 idle cycles after the last download byte
`timescale 1ns/10ps
`include "sys1_rom_macros.svh"

module tb_sys1_rom;

	localparam int CLK_PERIOD = 100;
	localparam int MAIN_WORDS = 40;
	localparam int SND_BYTES  = 30;
	localparam int MIX_READS  = 60;
	localparam int JUNK_BYTES = 30;
	// Download bytes, idle gaps, reads and read backs of all tests
	localparam int TEST_CYCLES = 5*MAIN_WORDS + 4*SND_BYTES + MIX_READS + JUNK_BYTES + 40;
	localparam int MARGIN      = 200;

	logic        clk_sys;
	logic        reset;
	logic        dl_active;
	logic        dl_wr;
	logic [7:0]  dl_index;
	logic [24:0] dl_addr;
	logic [7:0]  dl_data;
	logic [3:0]  main_sel;
	logic        slap_n;
	logic [14:0] main_addr;
	logic [2:0]  snd_sel;
	logic [13:0] snd_addr;
	logic [15:0] main_data;
	logic [7:0]  snd_data;

	integer seed;
	// ROM model keyed by select number and word or byte address
	logic [15:0] main_model [int];
	logic [7:0]  snd_model [int];
	int          main_keys [$];
	int          main_rec_sel [MAIN_WORDS];
	logic [14:0] main_rec_addr [MAIN_WORDS];
	int          snd_rec_sel [SND_BYTES];
	logic [13:0] snd_rec_addr [SND_BYTES];
	// Read in flight with its data due one cycle later
	bit          pend;
	string       pend_name;
	logic [15:0] pend_main;
	logic [7:0]  pend_snd;

	sys1_rom_top u_dut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.main_sel  (main_sel),
		.slap_n    (slap_n),
		.main_addr (main_addr),
		.snd_sel   (snd_sel),
		.snd_addr  (snd_addr),
		.main_data (main_data),
		.snd_data  (snd_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD/2) clk_sys = ~clk_sys;
	end

	// ##############################
	// Model helpers
	// ##############################

	// Select 0, 3 and 4 are the 16K ROMs that ignore address bit 14
	function automatic int main_key(input int sel, input logic [14:0] addr);
		if (sel == 0 || sel >= 3)
			return sel * 32768 + int'(addr[13:0]);
		return sel * 32768 + int'(addr);
	endfunction

	// Select 0 is 11J, 1 is 10B, 2 is 12B, 3 is 14B, 4 the protected 16B
	function automatic logic [24:0] main_dl_addr(input int sel, input logic [14:0] w,
		input logic odd);
		case (sel)
			0: return {`SYS1_BASE_SM2, w[13:0], odd};
			1: return {`SYS1_BASE_LG0, w, odd};
			2: return {`SYS1_BASE_LG1, w, odd};
			3: return {`SYS1_BASE_SM0, w[13:0], odd};
			default: return {`SYS1_BASE_SM1, w[13:0], odd};
		endcase
	endfunction

	// 13D, 14D, 16D
	function automatic logic [24:0] snd_dl_addr(input int sel, input logic [13:0] a);
		case (sel)
			0: return {`SYS1_BASE_SND0, a};
			1: return {`SYS1_BASE_SND1, a};
			default: return {`SYS1_BASE_SND2, a};
		endcase
	endfunction

	// Lowest active select wins and none active reads zero
	function automatic logic [15:0] expect_main(input logic [4:0] sel5, input logic [14:0] addr);
		for (int i = 0; i < 5; i++) begin
			if (!sel5[i])
				return main_model[main_key(i, addr)];
		end
		return 16'h0000;
	endfunction

	function automatic logic [7:0] expect_snd(input logic [2:0] sel3, input logic [13:0] addr);
		for (int i = 0; i < 3; i++) begin
			if (!sel3[i])
				return snd_model[i * 16384 + int'(addr)];
		end
		return 8'h00;
	endfunction

	task automatic record_main(input int sel, input logic [14:0] w, input logic [15:0] data);
		int key;
		key = main_key(sel, w);
		if (!main_model.exists(key))
			main_keys.push_back(key);
		main_model[key] = data;
	endtask

	// ##############################
	// Drive and check
	// ##############################

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("error %s expected %h actual %h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// One byte per cycle while strobes follow back to back
	task automatic send_byte(input logic [24:0] a, input logic [7:0] d, input logic act,
		input logic [7:0] idx);
		@(posedge clk_sys);
		#10;
		dl_active = act;
		dl_wr     = 1'b1;
		dl_index  = idx;
		dl_addr   = a;
		dl_data   = d;
	endtask

	// Strobe off and 3 idle cycles so the last write has landed
	task automatic end_download();
		@(posedge clk_sys);
		#10;
		dl_wr     = 1'b0;
		dl_active = 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic download_word(input int sel, input logic [14:0] w, input logic [15:0] data);
		send_byte(main_dl_addr(sel, w, 1'b0), data[15:8], 1'b1, 8'd0);
		send_byte(main_dl_addr(sel, w, 1'b1), data[7:0], 1'b1, 8'd0);
		record_main(sel, w, data);
	endtask

	// Compares the read in flight with both data buses
	task automatic check_pending();
		if (pend) begin
			check_value({pend_name, "_main"}, pend_main, main_data);
			check_value({pend_name, "_snd"}, {8'h00, pend_snd}, {8'h00, snd_data});
		end
		pend = 1'b0;
	endtask

	// Checks the previous read and drives a new one
	task automatic issue_read(input string name, input logic [4:0] sel5, input logic [14:0] maddr,
		input logic [2:0] sel3, input logic [13:0] saddr);
		@(posedge clk_sys);
		#10;
		check_pending();
		main_sel  = sel5[3:0];
		slap_n    = sel5[4];
		main_addr = maddr;
		snd_sel   = sel3;
		snd_addr  = saddr;
		pend      = 1'b1;
		pend_name = name;
		pend_main = expect_main(sel5, maddr);
		pend_snd  = expect_snd(sel3, saddr);
	endtask

	// Idle read closes a burst and is checked one cycle later
	task automatic end_reads();
		issue_read("idle", 5'h1f, 15'd0, 3'b111, 14'd0);
		@(posedge clk_sys);
		#10;
		check_pending();
	endtask

	task automatic read_back_main(input string name);
		logic [4:0] sel5;
		for (int i = 0; i < MAIN_WORDS; i++) begin
			sel5 = ~(5'b00001 << main_rec_sel[i]);
			issue_read(name, sel5, main_rec_addr[i], 3'b111, 14'($random(seed)));
		end
		end_reads();
	endtask

	task automatic read_back_snd(input string name);
		logic [2:0] sel3;
		for (int i = 0; i < SND_BYTES; i++) begin
			sel3 = ~(3'b001 << snd_rec_sel[i]);
			issue_read(name, 5'h1f, 15'($random(seed)), sel3, snd_rec_addr[i]);
		end
		end_reads();
	endtask

	// Watchdog
	initial begin
		#((TEST_CYCLES + MARGIN) * CLK_PERIOD);
		$display("Watchdog: the run did not finish in the expected time");
		$display("Test failed");
		$fatal(1, "timeout");
	end

	// ##############################
	// Test sequence
	// ##############################

	initial begin
		int          key;
		int          msel;
		int          j;
		logic [4:0]  sel5;
		logic [2:0]  sel3;
		logic [14:0] w;
		logic [13:0] a;
		logic [15:0] wdata;
		logic [7:0]  bdata;
		logic [24:0] junk_addr;
		seed      = 83939;
		pend      = 1'b0;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_index  = 8'd0;
		dl_addr   = '0;
		dl_data   = 8'd0;
		main_sel  = 4'hf;
		slap_n    = 1'b1;
		main_addr = '0;
		snd_sel   = 3'h7;
		snd_addr  = '0;
		repeat (2) @(posedge clk_sys);
		#10;
		reset = 1'b0;

		// Idle outputs after reset
		@(posedge clk_sys);
		#10;
		check_value("reset_main", 16'h0000, main_data);
		check_value("reset_snd", 16'h0000, {8'h00, snd_data});

		// Words into all five main ROMs with single select reads
		for (int i = 0; i < MAIN_WORDS; i++) begin
			w     = $random(seed);
			wdata = $random(seed);
			main_rec_sel[i]  = i % 5;
			main_rec_addr[i] = w;
			download_word(i % 5, w, wdata);
		end
		end_download();
		read_back_main("main_single");

		// Bytes into the three sound ROMs
		for (int i = 0; i < SND_BYTES; i++) begin
			a     = $random(seed);
			bdata = $random(seed);
			snd_rec_sel[i]  = i % 3;
			snd_rec_addr[i] = a;
			send_byte(snd_dl_addr(i % 3, a), bdata, 1'b1, 8'd0);
			snd_model[(i % 3) * 16384 + int'(a)] = bdata;
		end
		end_download();
		read_back_snd("snd_single");

		// Several selects at once and some reads with none
		for (int i = 0; i < MIX_READS; i++) begin
			key  = main_keys[{$random(seed)} % main_keys.size()];
			msel = key / 32768;
			w    = 15'(key % 32768);
			if (msel == 0 || msel >= 3)
				w[14] = $random(seed);
			// Lower selects off, chosen one on, higher ones random
			sel5 = 5'($random(seed)) | ((5'b00001 << msel) - 5'b00001);
			sel5[msel] = 1'b0;
			j    = i % SND_BYTES;
			sel3 = 3'($random(seed)) | ((3'b001 << snd_rec_sel[j]) - 3'b001);
			sel3[snd_rec_sel[j]] = 1'b0;
			if (i % 8 == 7) begin
				sel5 = 5'h1f;
				sel3 = 3'h7;
			end
			issue_read("mixed", sel5, w, sel3, snd_rec_addr[j]);
		end
		end_reads();

		// Ignored bytes between a pair keep the held even byte
		w     = $random(seed);
		wdata = $random(seed);
		send_byte(main_dl_addr(1, w, 1'b0), wdata[15:8], 1'b1, 8'd0);
		send_byte(main_dl_addr(1, w, 1'b0), ~wdata[15:8], 1'b1, 8'd1);
		send_byte(main_dl_addr(1, w, 1'b0), ~wdata[15:8], 1'b0, 8'd0);
		send_byte(main_dl_addr(1, w, 1'b1), wdata[7:0], 1'b1, 8'd0);
		record_main(1, w, wdata);
		end_download();
		issue_read("held_byte", 5'b11101, w, 3'b111, 14'd0);
		end_reads();

		// Bytes that must not write anything
		for (int i = 0; i < JUNK_BYTES; i++) begin
			bdata = $random(seed);
			j     = {$random(seed)} % MAIN_WORDS;
			junk_addr = {$random(seed)} % 32'h80000;
			// Above the sound ROMs when bit 0 of the data is set
			if (bdata[0])
				junk_addr = junk_addr + 25'h0C4000;
			case (i % 3)
				0: send_byte(main_dl_addr(main_rec_sel[j], main_rec_addr[j], 1'b1), bdata,
					1'b1, 8'd1 + 8'({$random(seed)} % 255));
				1: send_byte(snd_dl_addr(snd_rec_sel[j % SND_BYTES], snd_rec_addr[j % SND_BYTES]),
					bdata, 1'b0, 8'd0);
				default: send_byte(junk_addr, bdata, 1'b1, 8'd0);
			endcase
		end
		end_download();
		read_back_main("main_after_junk");
		read_back_snd("snd_after_junk");

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* hdl/sys1_rom_top.sv */
// Single clock domain; write lands 2 cycles after the byte, read data follows the address by 1 cycle
`timescale 1ns/10ps
`include "sys1_rom_macros.svh"

module sys1_rom_top
	import rom_bus_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	// Host download stream
	input  logic                    dl_active,
	input  logic                    dl_wr,
	input  logic [7:0]              dl_index,
	input  logic [`SYS1_DL_AW-1:0]  dl_addr,
	input  logic [7:0]              dl_data,
	// Main program bus, active low selects
	input  logic [3:0]              main_sel,
	input  logic                    slap_n,
	input  logic [`SYS1_LG_AW-1:0]  main_addr,
	// Sound bus, active low selects
	input  logic [2:0]              snd_sel,
	input  logic [`SYS1_SM_AW-1:0]  snd_addr,
	output logic [`SYS1_MAIN_DW-1:0] main_data,
	output logic [`SYS1_SND_DW-1:0]  snd_data
);

	// ############################
	// Internal buses
	// ############################

	// Protected bank rides above the four ROM selects
	main_sel_t sel_main;

	assign sel_main = {slap_n, main_sel};

	rom_load_if  u_load_if ();
	rom_fetch_if u_fetch_if ();

	// ############################
	// Download path
	// ############################

	// Byte pairing and region decode
	rom_loader u_loader (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.load      (u_load_if)
	);

	// Eight dual port ROM images
	rom_bank_store u_store (
		.clk_sys (clk_sys),
		.load    (u_load_if),
		.fetch   (u_fetch_if)
	);

	// ############################
	// Fetch path
	// ############################

	// Select alignment and board priority
	rom_fetch_mux u_fetch_mux (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.main_addr (main_addr),
		.main_sel  (sel_main),
		.snd_addr  (snd_addr),
		.snd_sel   (snd_sel),
		.main_data (main_data),
		.snd_data  (snd_data),
		.fetch     (u_fetch_if)
	);

endmodule

/* hdl/rom_fetch_mux.sv */
// Selects are active low; with several active the lowest select bit wins, with none data is zero
`timescale 1ns/10ps
`include "sys1_rom_macros.svh"

module rom_fetch_mux
	import rom_bus_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [`SYS1_LG_AW-1:0] main_addr,
	input  main_sel_t              main_sel,
	input  logic [`SYS1_SM_AW-1:0] snd_addr,
	input  snd_sel_t               snd_sel,
	output main_word_t             main_data,
	output snd_byte_t              snd_data,
	rom_fetch_if.fetch             fetch
);

	main_sel_t main_sel_q;
	snd_sel_t  snd_sel_q;

	// Addresses go straight to the memories
	assign fetch.main_addr = main_addr;
	assign fetch.snd_addr  = snd_addr;

	// ############################
	// Select alignment
	// ############################

	// One stage to line up with the registered ROM data
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			main_sel_q <= '1;
			snd_sel_q  <= '1;
		end else begin
			main_sel_q <= main_sel;
			snd_sel_q  <= snd_sel;
		end
	end

	// ############################
	// Priority selection
	// ############################

	// Board order 11J, 10B, 12B, 14B, then protected bank 16B
	always_comb begin
		if (!main_sel_q[0])
			main_data = fetch.sm2_q;
		else if (!main_sel_q[1])
			main_data = fetch.lg0_q;
		else if (!main_sel_q[2])
			main_data = fetch.lg1_q;
		else if (!main_sel_q[3])
			main_data = fetch.sm0_q;
		else if (!main_sel_q[4])
			main_data = fetch.sm1_q;
		else
			main_data = '0;
	end

	// Sound order 13D, 14D, 16D
	always_comb begin
		if (!snd_sel_q[0])
			snd_data = fetch.snd0_q;
		else if (!snd_sel_q[1])
			snd_data = fetch.snd1_q;
		else if (!snd_sel_q[2])
			snd_data = fetch.snd2_q;
		else
			snd_data = '0;
	end

endmodule

/* hdl/rom_bank_store.sv */
// Memory content is undefined until downloaded; reads always return one cycle after the address
`timescale 1ns/10ps
`include "sys1_rom_macros.svh"

module rom_bank_store
	import rom_map_pkg::*;
	import rom_bus_pkg::*;
(
	input  logic        clk_sys,
	rom_load_if.store   load,
	rom_fetch_if.store  fetch
);

	// ############################
	// Region memories
	// ############################

	// 10B and 12B, 32K words
	main_word_t mem_lg0  [0:(2**`SYS1_LG_AW)-1];
	main_word_t mem_lg1  [0:(2**`SYS1_LG_AW)-1];
	// 14B, 16B and 11J, 16K words
	main_word_t mem_sm0  [0:(2**`SYS1_SM_AW)-1];
	main_word_t mem_sm1  [0:(2**`SYS1_SM_AW)-1];
	main_word_t mem_sm2  [0:(2**`SYS1_SM_AW)-1];
	// 13D, 14D and 16D, 16K bytes
	snd_byte_t  mem_snd0 [0:(2**`SYS1_SM_AW)-1];
	snd_byte_t  mem_snd1 [0:(2**`SYS1_SM_AW)-1];
	snd_byte_t  mem_snd2 [0:(2**`SYS1_SM_AW)-1];

	// ############################
	// Download write side
	// ############################

	// Region steers the pulse to exactly one memory
	always_ff @(posedge clk_sys) begin
		if (load.we) begin
			case (load.region)
				REG_10B: mem_lg0[load.addr] <= load.wdata;
				REG_12B: mem_lg1[load.addr] <= load.wdata;
				// Small ROMs drop the top address bit
				REG_14B: mem_sm0[load.addr[`SYS1_SM_AW-1:0]] <= load.wdata;
				REG_16B: mem_sm1[load.addr[`SYS1_SM_AW-1:0]] <= load.wdata;
				REG_11J: mem_sm2[load.addr[`SYS1_SM_AW-1:0]] <= load.wdata;
				// Sound bytes ride in the low half
				REG_13D: mem_snd0[load.addr[`SYS1_SM_AW-1:0]] <= load.wdata[7:0];
				REG_14D: mem_snd1[load.addr[`SYS1_SM_AW-1:0]] <= load.wdata[7:0];
				REG_16D: mem_snd2[load.addr[`SYS1_SM_AW-1:0]] <= load.wdata[7:0];
				default: ;
			endcase
		end
	end

	// ############################
	// Board read side
	// ############################

	// All ROMs read every cycle, the fetch mux picks one
	always_ff @(posedge clk_sys) begin
		fetch.lg0_q  <= mem_lg0[fetch.main_addr];
		fetch.lg1_q  <= mem_lg1[fetch.main_addr];
		// Low 14 bits of the main bus address
		fetch.sm0_q  <= mem_sm0[fetch.main_addr[`SYS1_SM_AW-1:0]];
		fetch.sm1_q  <= mem_sm1[fetch.main_addr[`SYS1_SM_AW-1:0]];
		fetch.sm2_q  <= mem_sm2[fetch.main_addr[`SYS1_SM_AW-1:0]];
		// Sound CPU bus
		fetch.snd0_q <= mem_snd0[fetch.snd_addr];
		fetch.snd1_q <= mem_snd1[fetch.snd_addr];
		fetch.snd2_q <= mem_snd2[fetch.snd_addr];
	end

endmodule

/* hdl/rom_loader.sv */
// Main ROM bytes must arrive as even byte then odd byte; the odd byte completes the word
`timescale 1ns/10ps
`include "sys1_rom_macros.svh"

module rom_loader
	import rom_map_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         dl_active,
	input  logic         dl_wr,
	input  logic [7:0]   dl_index,
	input  dl_addr_u     dl_addr,
	input  logic [7:0]   dl_data,
	rom_load_if.loader   load
);

	// ############################
	// Strobe qualification
	// ############################

	logic        dl_strobe;
	logic        is_main;
	logic        is_snd;
	logic [7:0]  held_byte;
	rom_region_e region_dec;

	// Only ROM index zero is ours, and only while a download runs
	assign dl_strobe = dl_active && dl_wr && (dl_index == 8'd0);

	// ############################
	// Region decode
	// ############################

	// Large banks first, then small, then sound
	always_comb begin
		region_dec = REG_NONE;
		if (dl_addr.lg.bank == `SYS1_BASE_LG0)
			region_dec = REG_10B;
		else if (dl_addr.lg.bank == `SYS1_BASE_LG1)
			region_dec = REG_12B;
		else if (dl_addr.sm.bank == `SYS1_BASE_SM0)
			region_dec = REG_14B;
		else if (dl_addr.sm.bank == `SYS1_BASE_SM1)
			region_dec = REG_16B;
		else if (dl_addr.sm.bank == `SYS1_BASE_SM2)
			region_dec = REG_11J;
		else if (dl_addr.snd.bank == `SYS1_BASE_SND0)
			region_dec = REG_13D;
		else if (dl_addr.snd.bank == `SYS1_BASE_SND1)
			region_dec = REG_14D;
		else if (dl_addr.snd.bank == `SYS1_BASE_SND2)
			region_dec = REG_16D;
	end

	// Word wide program ROMs
	assign is_main = region_dec inside {REG_10B, REG_12B, REG_14B, REG_16B, REG_11J};
	// Byte wide sound ROMs
	assign is_snd  = region_dec inside {REG_13D, REG_14D, REG_16D};

	// ############################
	// Byte pairing and write pulse
	// ############################

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load.we   <= 1'b0;
			held_byte <= '0;
		end else begin
			// Odd main byte closes a word, every sound byte writes
			load.we <= dl_strobe && ((is_main && dl_addr.lg.offset[0]) || is_snd);
			// Even byte waits for its partner
			if (dl_strobe && !dl_addr.lg.offset[0])
				held_byte <= dl_data;
		end
	end

	// Write payload, only meaningful with we
	always_ff @(posedge clk_sys) begin
		load.region <= region_dec;
		if (is_snd) begin
			load.addr  <= {1'b0, dl_addr.snd.offset};
			load.wdata <= {8'h00, dl_data};
		end else begin
			// Even byte is the upper half of the word
			load.addr  <= dl_addr.lg.offset[15:1];
			load.wdata <= {held_byte, dl_data};
		end
	end

endmodule

/* hdl/rom_port_if.sv */
// Load and fetch ports of the ROM store; no handshake, every write and read is taken at once
`timescale 1ns/10ps
`include "sys1_rom_macros.svh"

// ############################
// Download write port
// ############################

interface rom_load_if
	import rom_map_pkg::*;
	import rom_bus_pkg::*;
();

	// Single cycle write pulse
	logic                  we;
	// Memory picked by the address decode
	rom_region_e           region;
	// Word address for main ROMs, byte address for sound
	logic [`SYS1_LG_AW-1:0] addr;
	// Sound writes use the low byte only
	main_word_t            wdata;

	modport loader (
		output we,
		output region,
		output addr,
		output wdata
	);

	modport store (
		input we,
		input region,
		input addr,
		input wdata
	);

endinterface

// ############################
// Board read port
// ############################

interface rom_fetch_if
	import rom_bus_pkg::*;
();

	// Addresses from the board buses
	logic [`SYS1_LG_AW-1:0] main_addr;
	logic [`SYS1_SM_AW-1:0] snd_addr;

	// Registered read data, one per ROM
	main_word_t lg0_q;
	main_word_t lg1_q;
	main_word_t sm0_q;
	main_word_t sm1_q;
	main_word_t sm2_q;
	snd_byte_t  snd0_q;
	snd_byte_t  snd1_q;
	snd_byte_t  snd2_q;

	modport fetch (
		output main_addr,
		output snd_addr,
		input  lg0_q, lg1_q, sm0_q, sm1_q, sm2_q,
		input  snd0_q, snd1_q, snd2_q
	);

	modport store (
		input  main_addr,
		input  snd_addr,
		output lg0_q, lg1_q, sm0_q, sm1_q, sm2_q,
		output snd0_q, snd1_q, snd2_q
	);

endinterface

/* hdl/rom_bus_pkg.sv */
// Read side types; all select vectors are active low as driven by the board logic
`include "sys1_rom_macros.svh"

package rom_bus_pkg;

	// ############################
	// Data words
	// ############################

	// Main program ROM word
	typedef logic [`SYS1_MAIN_DW-1:0] main_word_t;

	// Sound ROM byte
	typedef logic [`SYS1_SND_DW-1:0] snd_byte_t;

	// ############################
	// Chip selects
	// ############################

	// Bits 3..0 board ROM selects
	// Bit 4 protected bank select
	typedef logic [4:0] main_sel_t;

	// One select per sound ROM
	typedef logic [2:0] snd_sel_t;

endpackage

/* hdl/rom_map_pkg.sv */
// Download side types; the address views assume the 25-bit host address of the ROM loader
`include "sys1_rom_macros.svh"

package rom_map_pkg;

	// ############################
	// Target regions
	// ############################

	// One code per on-chip ROM, REG_NONE for bytes outside the map
	typedef enum logic [3:0] {
		REG_NONE,
		REG_10B,
		REG_12B,
		REG_14B,
		REG_16B,
		REG_11J,
		REG_13D,
		REG_14D,
		REG_16D
	} rom_region_e;

	// ############################
	// Download address views
	// ############################

	// Same address word, three bank/offset splits
	typedef union packed {
		// Large main ROMs, 64K byte window
		struct packed {
			logic [8:0]  bank;
			logic [15:0] offset;
		} lg;
		// Small main ROMs, 32K byte window
		struct packed {
			logic [9:0]  bank;
			logic [14:0] offset;
		} sm;
		// Sound ROMs, 16K byte window
		struct packed {
			logic [10:0] bank;
			logic [13:0] offset;
		} snd;
	} dl_addr_u;

endpackage

/* include/sys1_rom_macros.svh */
// Widths and region bases follow the board's ROM download order; changing a base moves that region
`ifndef SYS1_ROM_MACROS_SVH
`define SYS1_ROM_MACROS_SVH

// ############################
// Bus widths
// ############################

// Host download address, byte granular
`define SYS1_DL_AW      25

// Large main ROMs, 32K words each
`define SYS1_LG_AW      15

// Small main ROMs in words, sound ROMs in bytes
`define SYS1_SM_AW      14

// Main program bus data
`define SYS1_MAIN_DW    16

// Sound bus data
`define SYS1_SND_DW     8

// ############################
// Region bases
// ############################

// Download address bits 24..16, large main ROMs 10B and 12B
`define SYS1_BASE_LG0   9'd8
`define SYS1_BASE_LG1   9'd9

// Bits 24..15, small main ROMs 14B, 16B and 11J
`define SYS1_BASE_SM0   10'd20
`define SYS1_BASE_SM1   10'd21
`define SYS1_BASE_SM2   10'd22

// Bits 24..14, sound ROMs 13D, 14D and 16D
`define SYS1_BASE_SND0  11'd46
`define SYS1_BASE_SND1  11'd47
`define SYS1_BASE_SND2  11'd48

`endif
